/* src/flash_pkg.sv */
package flash_pkg;

    // AXI response codes
    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    // Standard serial NOR read command
    localparam logic [7:0] read_opcode = 8'h03;

    // Flash address and bus data widths
    localparam int flash_addr_bits = 24;
    localparam int data_bits       = 64;
    localparam int bytes_per_word  = data_bits / 8;

    typedef logic [flash_addr_bits-1:0] addr_t;
    typedef logic [data_bits-1:0] word_t;

endpackage

/* src/byte_if.sv */
`timescale 1ns/1ns

interface byte_if;

    // Request side, driven by the word assembler
    logic               start_read;
    flash_pkg::addr_t   addr;
    logic               keep_reading;

    // Received bytes, driven by the flash reader
    logic               data_ready;
    logic [7:0]         data;

    modport reader (
        input  start_read,
        input  addr,
        input  keep_reading,
        output data_ready,
        output data
    );

    modport assembler (
        output start_read,
        output addr,
        output keep_reading,
        input  data_ready,
        input  data
    );

endinterface

/* src/word_if.sv */
`timescale 1ns/1ns

interface word_if;

    // Read request from the bus port
    logic               start;
    flash_pkg::addr_t   addr;

    // Finished word, held until the next start
    flash_pkg::word_t   word;
    logic               word_valid;

    modport assembler (
        input  start,
        input  addr,
        output word,
        output word_valid
    );

    modport port (
        output start,
        output addr,
        input  word,
        input  word_valid
    );

endinterface

/* src/flash_reader.sv */
`timescale 1ns/1ns

module flash_reader #(
    parameter int CLK_DIV = 2
) (
    input  logic  bus,
    input  logic  rst,
    byte_if.reader link,
    output logic  cs,
    output logic  sclk,
    output logic  si,
    input  logic  so,
    output logic  wp,
    output logic  hold
);

    localparam int PHASE_W = $clog2(CLK_DIV + 1);
    localparam logic [PHASE_W-1:0] LAST_PHASE = PHASE_W'(CLK_DIV - 1);

    // Bits 0 to 31 are command and address, 32 to 39 one received byte
    localparam logic [5:0] LAST_BIT = 6'd39;
    localparam logic [5:0] FIRST_RX_BIT = 6'd32;

    logic [PHASE_W-1:0] phase;
    logic [5:0]         bit_cnt;
    logic [31:0]        shift_reg;
    logic [7:0]         rx_byte;
    logic               more;
    logic               tick;
    logic               rise;
    logic               fall;
    logic               rx_phase;

    // One sclk edge every CLK_DIV bus cycles while selected
    assign tick     = !cs && (phase == LAST_PHASE);
    assign rise     = tick && !sclk;
    assign fall     = tick && sclk;
    assign rx_phase = bit_cnt[5];

    assign si   = shift_reg[31];
    assign wp   = 1'b1;
    assign hold = 1'b1;

    assign link.data = rx_byte;

    always_ff @(posedge bus) begin
        if (rst) begin
            cs             <= 1'b1;
            sclk           <= 1'b0;
            phase          <= '0;
            bit_cnt        <= '0;
            more           <= 1'b0;
            link.data_ready <= 1'b0;
        end else begin
            link.data_ready <= rise && (bit_cnt == LAST_BIT);
            if (cs) begin
                if (link.start_read) begin
                    cs      <= 1'b0;
                    phase   <= '0;
                    bit_cnt <= '0;
                end
            end else if (!tick) begin
                phase <= phase + 1'b1;
            end else begin
                phase <= '0;
                sclk  <= !sclk;
                if (rise && bit_cnt == LAST_BIT) begin
                    // Byte boundary, decide now whether another byte follows
                    more <= link.keep_reading;
                end
                if (fall) begin
                    if (bit_cnt != LAST_BIT) begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end else if (more) begin
                        bit_cnt <= FIRST_RX_BIT;
                    end else begin
                        cs <= 1'b1;
                    end
                end
            end
        end
    end

    // Command shifts out MSB first, data shifts in MSB first
    always_ff @(posedge bus) begin
        if (cs && link.start_read) begin
            shift_reg <= {flash_pkg::read_opcode, link.addr};
        end else if (fall && !rx_phase) begin
            shift_reg <= {shift_reg[30:0], 1'b0};
        end
        if (rise && rx_phase) begin
            rx_byte <= {rx_byte[6:0], so};
        end
    end

endmodule

/* src/word_assembler.sv */
`timescale 1ns/1ns

module word_assembler (
    input  logic       bus,
    input  logic       rst,
    byte_if.assembler  link,
    word_if.assembler  port
);

    localparam logic [3:0] WORD_BYTES = 4'(flash_pkg::bytes_per_word);

    logic [3:0]       byte_cnt;
    flash_pkg::word_t buffer;

    // Requests go straight through to the reader
    assign link.start_read   = port.start;
    assign link.addr         = port.addr;
    assign link.keep_reading = byte_cnt > 4'd1;

    assign port.word = buffer;

    always_ff @(posedge bus) begin
        if (rst) begin
            byte_cnt        <= '0;
            port.word_valid <= 1'b0;
        end else if (port.start) begin
            byte_cnt        <= WORD_BYTES;
            port.word_valid <= 1'b0;
        end else if (link.data_ready && byte_cnt != 4'd0) begin
            byte_cnt <= byte_cnt - 1'b1;
            if (byte_cnt == 4'd1) begin
                port.word_valid <= 1'b1;
            end
        end
    end

    // New bytes enter at the top so the first one ends up in bits 7:0
    always_ff @(posedge bus) begin
        if (link.data_ready) begin
            buffer <= {link.data, buffer[flash_pkg::data_bits-1:8]};
        end
    end

endmodule

/* src/axi_slave_port.sv */
`timescale 1ns/1ns

module axi_slave_port (
    input  logic                            bus,
    input  logic                            rst,
    input  logic                            arvalid,
    output logic                            arready,
    input  logic [31:0]                     araddr,
    output logic                            rvalid,
    input  logic                            rready,
    output logic [flash_pkg::data_bits-1:0] rdata,
    output logic [1:0]                      rresp,
    input  logic                            awvalid,
    input  logic                            wvalid,
    output logic                            awready,
    output logic                            wready,
    output logic                            bvalid,
    input  logic                            bready,
    output logic [1:0]                      bresp,
    word_if.port                            link
);

    logic ar_fire;
    logic r_fire;
    logic write_accept;

    assign ar_fire = arvalid && arready;
    assign r_fire  = rvalid && rready;

    // Start the flash read in the AR handshake cycle
    assign link.start = ar_fire;
    assign link.addr  = araddr[flash_pkg::flash_addr_bits-1:0];

    assign rdata = link.word;
    assign rresp = flash_pkg::resp_okay;

    always_ff @(posedge bus) begin
        if (rst) begin
            arready <= 1'b1;
        end else if (ar_fire) begin
            arready <= 1'b0;
        end else if (r_fire) begin
            arready <= 1'b1;
        end
    end

    // A request is outstanding while arready is low
    always_ff @(posedge bus) begin
        if (rst) begin
            rvalid <= 1'b0;
        end else if (r_fire) begin
            rvalid <= 1'b0;
        end else if (link.word_valid && !arready) begin
            rvalid <= 1'b1;
        end
    end

    // Writes are never performed, each one gets an error response
    assign awready = write_accept;
    assign wready  = write_accept;
    assign bresp   = flash_pkg::resp_slverr;

    always_ff @(posedge bus) begin
        if (rst) begin
            write_accept <= 1'b0;
            bvalid       <= 1'b0;
        end else begin
            write_accept <= awvalid && wvalid && !write_accept && !bvalid;
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end else if (write_accept) begin
                bvalid <= 1'b1;
            end
        end
    end

endmodule

/* src/axi_flash_top.sv */
`timescale 1ns/1ns

module axi_flash_top #(
    parameter int CLK_DIV = 2
) (
    input  logic                            bus,
    input  logic                            rst,

    input  logic                            arvalid,
    output logic                            arready,
    input  logic [31:0]                     araddr,
    output logic                            rvalid,
    input  logic                            rready,
    output logic [flash_pkg::data_bits-1:0] rdata,
    output logic [1:0]                      rresp,

    input  logic                            awvalid,
    input  logic                            wvalid,
    output logic                            awready,
    output logic                            wready,
    output logic                            bvalid,
    input  logic                            bready,
    output logic [1:0]                      bresp,

    // Serial flash pins
    output logic                            cs,
    output logic                            sclk,
    output logic                            si,
    input  logic                            so,
    output logic                            wp,
    output logic                            hold
);

    byte_if byte_link ();
    word_if word_link ();

    flash_reader #(
        .CLK_DIV (CLK_DIV)
    ) flash_reader_inst (
        .bus  (bus),
        .rst  (rst),
        .link (byte_link.reader),
        .cs   (cs),
        .sclk (sclk),
        .si   (si),
        .so   (so),
        .wp   (wp),
        .hold (hold)
    );

    word_assembler word_assembler_inst (
        .bus  (bus),
        .rst  (rst),
        .link (byte_link.assembler),
        .port (word_link.assembler)
    );

    axi_slave_port axi_slave_port_inst (
        .bus     (bus),
        .rst     (rst),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp),
        .awvalid (awvalid),
        .wvalid  (wvalid),
        .awready (awready),
        .wready  (wready),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp),
        .link    (word_link.port)
    );

endmodule

/* testbench/spi_flash_model.sv */
`timescale 1ns/1ns

module spi_flash_model (
    input  logic        cs,
    input  logic        sclk,
    input  logic        si,
    output logic        so,
    output logic [31:0] command,
    output int          rise_count
);

    logic [23:0] byte_addr;
    logic [7:0]  out_shift;

    // Array content rule, one byte per flash address
    function automatic logic [7:0] flash_byte(input logic [23:0] a);
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ 8'ha5;
    endfunction

    // Falling cs starts a frame, rising sclk samples si
    always @(posedge sclk or negedge cs) begin
        if (!sclk) begin
            rise_count <= 0;
        end else if (!cs) begin
            if (rise_count < 32) begin
                command <= {command[30:0], si};
            end
            rise_count <= rise_count + 1;
        end
    end

    // Data goes out on falling sclk, MSB first, address steps per byte
    always @(negedge sclk) begin
        if (!cs && rise_count >= 32) begin
            if (rise_count == 32) begin
                byte_addr = command[23:0];
            end else if (rise_count % 8 == 0) begin
                byte_addr = byte_addr + 24'd1;
            end
            if (rise_count % 8 == 0) begin
                out_shift = flash_byte(byte_addr);
            end
            so <= out_shift[7];
            out_shift = {out_shift[6:0], 1'b0};
        end
    end

endmodule

/* testbench/tb_axi_flash.sv */
`timescale 1ns/1ns

module tb_axi_flash;

    localparam int num_reads    = 24;
    localparam int num_writes   = 16;
    localparam int read_cycles  = 400;
    localparam int write_budget = 2400;
    localparam int max_cycles   = num_reads * read_cycles + write_budget;
    localparam logic [31:0] seed     = 32'h58388986;
    localparam logic [7:0]  read_cmd = 8'h03;
    localparam logic [1:0]  okay     = 2'b00;
    localparam logic [1:0]  slverr   = 2'b10;

    logic        bus;
    logic        rst;
    logic        arvalid;
    logic        arready;
    logic [31:0] araddr;
    logic        rvalid;
    logic        rready;
    logic [63:0] rdata;
    logic [1:0]  rresp;
    logic        awvalid;
    logic        wvalid;
    logic        awready;
    logic        wready;
    logic        bvalid;
    logic        bready;
    logic [1:0]  bresp;
    logic        cs;
    logic        sclk;
    logic        si;
    logic        so;
    logic        wp;
    logic        hold;

    logic [31:0] flash_command;
    int          flash_rises;
    logic [23:0] expected_addr;
    logic [63:0] expected_word;
    int          cycle_count = 0;
    int          read_stalls;
    int          write_stalls;

    axi_flash_top #(.CLK_DIV(2)) axi_flash_top_inst (.*);

    spi_flash_model flash_model_inst (
        .cs         (cs),
        .sclk       (sclk),
        .si         (si),
        .so         (so),
        .command    (flash_command),
        .rise_count (flash_rises)
    );

    always #10 bus = ~bus;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Little-endian word of eight flash bytes starting at a
    function automatic logic [63:0] expected_read(input logic [23:0] a);
        logic [63:0] w;
        w = '0;
        for (int k = 0; k < 8; k++) begin
            w[8*k +: 8] = a[7:0] ^ a[15:8] ^ a[23:16] ^ 8'ha5;
            a = a + 24'd1;
        end
        return w;
    endfunction

    task automatic report_error(input string msg);
        $display("** Error at %0t ns: %s", $time, msg);
        $display("RESULT: FAIL");
        $fatal(1, "Check failed");
    endtask

    task automatic next_cycle;
        @(posedge bus);
        #1;
    endtask

    task automatic run_reads;
        logic [31:0] state;
        logic        accepted;
        int          n;
        state = seed;
        for (n = 0; n < num_reads; n++) begin
            state = lcg_next(state);
            repeat (state[31:30]) next_cycle();
            state = lcg_next(state);
            expected_addr = state[23:0];
            expected_word = expected_read(state[23:0]);
            araddr = state;
            arvalid = 1'b1;
            do begin
                accepted = arready;
                next_cycle();
            end while (!accepted);
            arvalid = 1'b0;
            // Roughly one stall cycle in four on rready
            do begin
                state = lcg_next(state);
                rready = state[31:30] != 2'b00;
                if (rvalid && !rready) begin
                    read_stalls++;
                end
                accepted = rvalid && rready;
                next_cycle();
            end while (!accepted);
            rready = 1'b0;
        end
    endtask

    task automatic run_writes;
        logic [31:0] state;
        logic        accepted;
        int          n;
        // Separate stream so writes interleave with reads differently
        state = ~seed;
        for (n = 0; n < num_writes; n++) begin
            state = lcg_next(state);
            repeat (state[31:28]) next_cycle();
            awvalid = 1'b1;
            wvalid = 1'b1;
            do begin
                accepted = awready;
                next_cycle();
            end while (!accepted);
            awvalid = 1'b0;
            wvalid = 1'b0;
            do begin
                state = lcg_next(state);
                bready = state[31];
                if (bvalid && !bready) begin
                    write_stalls++;
                end
                accepted = bvalid && bready;
                next_cycle();
            end while (!accepted);
            bready = 1'b0;
        end
    endtask

    reset_state: assert property (@(posedge bus)
        rst |=> arready && !rvalid && !awready && !wready && !bvalid && cs && !sclk)
        else report_error("wrong output state after reset");
    pins_high: assert property (@(posedge bus) disable iff (rst) wp && hold)
        else report_error("wp or hold not high");
    read_data: assert property (@(posedge bus) disable iff (rst)
        rvalid && rready |-> rdata == expected_word && rresp == okay)
        else report_error("read data or response mismatch");
    read_hold: assert property (@(posedge bus) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
        else report_error("read channel changed while stalled");
    read_blocks_ar: assert property (@(posedge bus) disable iff (rst) rvalid |-> !arready)
        else report_error("arready high while rvalid pending");
    read_release: assert property (@(posedge bus) disable iff (rst)
        rvalid && rready |=> !rvalid && arready)
        else report_error("rvalid or arready wrong after R handshake");
    flash_frame: assert property (@(posedge bus) disable iff (rst)
        $rose(cs) |-> flash_command == {read_cmd, expected_addr} && flash_rises == 96)
        else report_error("flash command, address or sclk edge count mismatch");
    write_pair: assert property (@(posedge bus) disable iff (rst) awready == wready)
        else report_error("awready and wready differ");
    write_requested: assert property (@(posedge bus) disable iff (rst)
        awready |-> awvalid && wvalid)
        else report_error("write ready without request");
    write_pulse: assert property (@(posedge bus) disable iff (rst)
        awready |=> !awready && bvalid)
        else report_error("write ready not a single pulse followed by bvalid");
    write_accept: assert property (@(posedge bus) disable iff (rst)
        $rose(awvalid && wvalid) |=> awready)
        else report_error("write request not accepted on next edge");
    b_resp: assert property (@(posedge bus) disable iff (rst) bvalid |-> bresp == slverr)
        else report_error("write response not SLVERR");
    b_hold: assert property (@(posedge bus) disable iff (rst) bvalid && !bready |=> bvalid)
        else report_error("bvalid dropped before bready");
    b_done: assert property (@(posedge bus) disable iff (rst) bvalid && bready |=> !bvalid)
        else report_error("bvalid still high after B handshake");

    always @(posedge bus) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("Timeout after %0d cycles with requests still open", cycle_count);
            $display("RESULT: FAIL");
            $fatal(1, "Timeout");
        end
    end

    initial begin
        bus = 1'b0;
        rst = 1'b1;
        arvalid = 1'b0;
        araddr = '0;
        rready = 1'b0;
        awvalid = 1'b0;
        wvalid = 1'b0;
        bready = 1'b0;
        expected_addr = '0;
        expected_word = '0;
        read_stalls = 0;
        write_stalls = 0;
        repeat (5) @(posedge bus);
        #1;
        rst = 1'b0;
        fork
            run_reads();
            run_writes();
        join
        // Let the checks on the last handshakes sample
        repeat (2) next_cycle();
        if (read_stalls > 0 && write_stalls > 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            $display("Back-pressure never exercised on the R or B channel");
            $display("RESULT: FAIL");
            $fatal(1, "Coverage incomplete");
        end
    end

endmodule

/* sources.f */
src/flash_pkg.sv
src/byte_if.sv
src/word_if.sv
src/flash_reader.sv
src/word_assembler.sv
src/axi_slave_port.sv
src/axi_flash_top.sv
testbench/spi_flash_model.sv
testbench/tb_axi_flash.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator, exit status follows the result
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f \
    --top-module tb_axi_flash -Mdir obj_dir

./obj_dir/Vtb_axi_flash
